//--- hdl/mmc_pkg.sv
// Shared types and MMC card constants for the SPI-mode block device front end.
`default_nettype none

package mmc_pkg;

   // Host command codes. The fourth code is ignored.
   typedef enum logic [1:0] {
      HOST_RESET = 2'd0,
      HOST_READ  = 2'd1,
      HOST_WRITE = 2'd2
   } host_cmd_e;

   // SPI byte operations queued from the sequencer to the engine.
   typedef enum logic [1:0] {
      OP_SEND    = 2'd0,
      OP_XFER    = 2'd1,
      OP_RELEASE = 2'd2
   } spi_op_e;

   typedef struct packed {
      spi_op_e    opcode;
      logic [7:0] data;
   } spi_op_t;

   typedef struct packed {
      logic       valid;
      logic [7:0] data;
   } spi_rsp_t;

   typedef logic [22:0] block_addr_t;
   typedef logic [15:0] word_t;

   // Command bytes, start bit and transmission bit included.
   localparam logic [7:0] CMD_GO_IDLE      = 8'h40;
   localparam logic [7:0] CMD_SEND_OP_COND = 8'h41;
   localparam logic [7:0] CMD_READ_SINGLE  = 8'h51;
   localparam logic [7:0] CMD_WRITE_SINGLE = 8'h58;

   // CMD0 needs a real CRC, the others are ignored in SPI mode.
   localparam logic [7:0] IDLE_CRC  = 8'h95;
   localparam logic [7:0] DUMMY_CRC = 8'h01;

   localparam logic [7:0] START_TOKEN = 8'hfe;
   localparam logic [7:0] FILL_BYTE   = 8'hff;

   // R1 responses.
   localparam logic [7:0] R1_IDLE  = 8'h01;
   localparam logic [7:0] R1_READY = 8'h00;

   // Low bits of the data response token when the block was accepted.
   localparam logic [4:0] DATA_ACCEPTED = 5'b00101;

   // Byte address is the block number times 512.
   localparam int BLOCK_SHIFT = 9;

endpackage

`default_nettype wire

//--- hdl/spi_op_queue.sv
// FIFO of pending SPI byte operations between the block sequencer and the byte engine.
`timescale 1ns/1ps
`default_nettype none

module spi_op_queue #(
   parameter int QUEUE_DEPTH = 8
) (
   input  logic              clk,
   input  logic              reset,
   input  mmc_pkg::spi_op_t  in_op,
   input  logic              in_valid,
   output logic              in_ready,
   output mmc_pkg::spi_op_t  out_op,
   output logic              out_valid,
   input  logic              out_ready
);

   localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
   localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

   mmc_pkg::spi_op_t mem [QUEUE_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign in_ready  = (count != CNT_W'(QUEUE_DEPTH));
   assign out_valid = (count != '0);
   assign out_op    = mem[rd_ptr];
   assign push      = in_valid && in_ready;
   assign pop       = out_valid && out_ready;

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= in_op;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= next_ptr(wr_ptr);
         if (pop)
            rd_ptr <= next_ptr(rd_ptr);
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

   a_count_bound: assert property (@(posedge clk) disable iff (reset)
      count <= CNT_W'(QUEUE_DEPTH))
      else $error("Queue count above depth.");

endmodule

`default_nettype wire

//--- hdl/spi_byte_engine.sv
// SPI mode 0 byte shifter that runs one queued operation at a time on the card pins.
`timescale 1ns/1ps
`default_nettype none

module spi_byte_engine #(
   parameter int CLK_DIV = 4
) (
   input  logic              clk,
   input  logic              reset,
   input  mmc_pkg::spi_op_t  op,
   input  logic              op_valid,
   output logic              op_ready,
   output mmc_pkg::spi_rsp_t rsp,
   output logic              mmc_cs,
   output logic              mmc_sclk,
   output logic              mmc_do,
   input  logic              mmc_di
);

   localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

   typedef enum logic {
      ENG_IDLE,
      ENG_SHIFT
   } eng_state_e;

   eng_state_e       state;
   logic [DIV_W-1:0] div_cnt;
   logic [2:0]       bit_cnt;
   logic [7:0]       shift;
   logic [7:0]       rx_byte;
   logic             is_xfer;
   logic             rsp_valid;

   assign op_ready = (state == ENG_IDLE);
   assign mmc_do   = shift[7];
   assign rsp      = '{valid: rsp_valid, data: rx_byte};

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state     <= ENG_IDLE;
         mmc_cs    <= 1'b1;
         mmc_sclk  <= 1'b0;
         shift     <= 8'hff;
         div_cnt   <= '0;
         bit_cnt   <= '0;
         is_xfer   <= 1'b0;
         rsp_valid <= 1'b0;
      end
      else
      begin
         rsp_valid <= 1'b0;
         case (state)
            ENG_IDLE:
            begin
               if (op_valid)
               begin
                  // Release clocks ones with the card deselected.
                  mmc_cs  <= (op.opcode == mmc_pkg::OP_RELEASE);
                  shift   <= (op.opcode == mmc_pkg::OP_RELEASE) ? 8'hff : op.data;
                  is_xfer <= (op.opcode == mmc_pkg::OP_XFER);
                  div_cnt <= '0;
                  bit_cnt <= '0;
                  state   <= ENG_SHIFT;
               end
            end
            ENG_SHIFT:
            begin
               if (div_cnt == DIV_W'(CLK_DIV - 1))
               begin
                  div_cnt  <= '0;
                  mmc_sclk <= !mmc_sclk;
                  if (!mmc_sclk)
                     rx_byte <= {rx_byte[6:0], mmc_di};
                  else
                  begin
                     shift   <= {shift[6:0], 1'b1};
                     bit_cnt <= bit_cnt + 1'b1;
                     if (bit_cnt == 3'd7)
                     begin
                        rsp_valid <= is_xfer;
                        state     <= ENG_IDLE;
                     end
                  end
               end
               else
                  div_cnt <= div_cnt + 1'b1;
            end
            default:
               state <= ENG_IDLE;
         endcase
      end
   end

   a_busy_while_clocking: assert property (@(posedge clk) disable iff (reset)
      mmc_sclk |-> !op_ready)
      else $error("Engine ready while SPI clock is high.");

endmodule

`default_nettype wire

//--- hdl/block_sequencer.sv
// Host-side FSM that turns reset, read and write requests into queued SPI byte operations.
`timescale 1ns/1ps
`default_nettype none

module block_sequencer #(
   parameter int WORDS_PER_BLOCK = 256
) (
   input  logic                 clk,
   input  logic                 reset,
   input  mmc_pkg::host_cmd_e   bd_cmd,
   input  logic                 bd_start,
   input  mmc_pkg::block_addr_t bd_addr,
   input  mmc_pkg::word_t       bd_data_in,
   input  logic                 bd_rd,
   input  logic                 bd_wr,
   output logic                 bd_bsy,
   output logic                 bd_err,
   output logic                 bd_iordy,
   output mmc_pkg::word_t       bd_data_out,
   output mmc_pkg::spi_op_t     op,
   output logic                 op_valid,
   input  logic                 op_ready,
   input  mmc_pkg::spi_rsp_t    rsp
);

   localparam int WC_W        = $clog2(WORDS_PER_BLOCK + 1);
   localparam int POWER_BYTES = 10;

   typedef enum logic [3:0] {
      ST_IDLE,
      ST_POWER,
      ST_CMD,
      ST_INIT_R1,
      ST_R1,
      ST_TOKEN,
      ST_RD_WORD,
      ST_HOST,
      ST_WR_WORD,
      ST_CRC,
      ST_DATA_RSP,
      ST_BUSY,
      ST_RELEASE
   } state_e;

   state_e               state;
   mmc_pkg::host_cmd_e   cmd_hold;
   mmc_pkg::block_addr_t addr_hold;
   mmc_pkg::word_t       rd_word;
   mmc_pkg::word_t       wr_word;
   logic [7:0]           cmd_code;
   logic [7:0]           cmd_byte;
   logic [31:0]          cmd_arg;
   logic [3:0]           byte_idx;
   logic [WC_W-1:0]      wc;
   logic                 inited;
   logic                 xfer_pending;
   logic                 is_write;
   logic                 push;
   logic                 got;

   function automatic logic [7:0] rw_cmd(input mmc_pkg::host_cmd_e c);
      return (c == mmc_pkg::HOST_WRITE) ? mmc_pkg::CMD_WRITE_SINGLE : mmc_pkg::CMD_READ_SINGLE;
   endfunction

   assign bd_bsy      = (state != ST_IDLE);
   assign bd_iordy    = (state == ST_HOST);
   assign bd_data_out = rd_word;
   assign is_write    = (cmd_hold == mmc_pkg::HOST_WRITE);
   assign push        = op_valid && op_ready;
   assign got         = xfer_pending && rsp.valid;

   // Init commands carry no argument.
   assign cmd_arg = (cmd_code == mmc_pkg::CMD_GO_IDLE || cmd_code == mmc_pkg::CMD_SEND_OP_COND) ?
                    32'd0 : 32'(addr_hold) << mmc_pkg::BLOCK_SHIFT;

   always_comb
   begin
      case (byte_idx)
         4'd0: cmd_byte = cmd_code;
         4'd1: cmd_byte = cmd_arg[31:24];
         4'd2: cmd_byte = cmd_arg[23:16];
         4'd3: cmd_byte = cmd_arg[15:8];
         4'd4: cmd_byte = cmd_arg[7:0];
         default:
            cmd_byte = (cmd_code == mmc_pkg::CMD_GO_IDLE) ? mmc_pkg::IDLE_CRC : mmc_pkg::DUMMY_CRC;
      endcase
   end

   always_comb
   begin
      op.opcode = mmc_pkg::OP_SEND;
      op.data   = mmc_pkg::FILL_BYTE;
      op_valid  = 1'b0;
      case (state)
         ST_POWER, ST_RELEASE:
         begin
            op.opcode = mmc_pkg::OP_RELEASE;
            op_valid  = 1'b1;
         end
         ST_CMD:
         begin
            op.data  = cmd_byte;
            op_valid = 1'b1;
         end
         ST_TOKEN:
         begin
            if (is_write)
            begin
               op.data  = mmc_pkg::START_TOKEN;
               op_valid = 1'b1;
            end
            else
            begin
               op.opcode = mmc_pkg::OP_XFER;
               op_valid  = !xfer_pending;
            end
         end
         ST_INIT_R1, ST_R1, ST_RD_WORD, ST_DATA_RSP, ST_BUSY:
         begin
            // One xfer in flight, answered before the next goes out.
            op.opcode = mmc_pkg::OP_XFER;
            op_valid  = !xfer_pending;
         end
         ST_WR_WORD:
         begin
            op.data  = byte_idx[0] ? wr_word[15:8] : wr_word[7:0];
            op_valid = 1'b1;
         end
         ST_CRC:
         begin
            op.data  = is_write ? 8'h00 : mmc_pkg::FILL_BYTE;
            op_valid = 1'b1;
         end
         default:
            op_valid = 1'b0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state        <= ST_IDLE;
         cmd_hold     <= mmc_pkg::HOST_RESET;
         cmd_code     <= mmc_pkg::CMD_GO_IDLE;
         byte_idx     <= '0;
         wc           <= '0;
         inited       <= 1'b0;
         xfer_pending <= 1'b0;
         bd_err       <= 1'b0;
      end
      else
      begin
         if (push && op.opcode == mmc_pkg::OP_XFER)
            xfer_pending <= 1'b1;
         else if (rsp.valid)
            xfer_pending <= 1'b0;

         case (state)
            ST_IDLE:
            begin
               if (bd_start && (bd_cmd inside {mmc_pkg::HOST_RESET, mmc_pkg::HOST_READ,
                                               mmc_pkg::HOST_WRITE}))
               begin
                  cmd_hold  <= bd_cmd;
                  addr_hold <= bd_addr;
                  bd_err    <= 1'b0;
                  byte_idx  <= '0;
                  wc        <= '0;
                  if (bd_cmd == mmc_pkg::HOST_RESET || !inited)
                  begin
                     inited <= 1'b0;
                     state  <= ST_POWER;
                  end
                  else
                  begin
                     cmd_code <= rw_cmd(bd_cmd);
                     state    <= ST_CMD;
                  end
               end
            end
            ST_POWER:
            begin
               // Dummy clocks with the card deselected before CMD0.
               if (push)
               begin
                  byte_idx <= byte_idx + 1'b1;
                  if (byte_idx == 4'(POWER_BYTES - 1))
                  begin
                     byte_idx <= '0;
                     cmd_code <= mmc_pkg::CMD_GO_IDLE;
                     state    <= ST_CMD;
                  end
               end
            end
            ST_CMD:
            begin
               if (push)
               begin
                  byte_idx <= byte_idx + 1'b1;
                  if (byte_idx == 4'd5)
                  begin
                     byte_idx <= '0;
                     if (cmd_code == mmc_pkg::CMD_GO_IDLE || cmd_code == mmc_pkg::CMD_SEND_OP_COND)
                        state <= ST_INIT_R1;
                     else
                        state <= ST_R1;
                  end
               end
            end
            ST_INIT_R1:
            begin
               if (got && rsp.data != mmc_pkg::FILL_BYTE)
               begin
                  if (cmd_code == mmc_pkg::CMD_GO_IDLE)
                     state <= (rsp.data == mmc_pkg::R1_IDLE) ? ST_RELEASE : ST_POWER;
                  else
                  begin
                     // Still idle means CMD1 is sent again after release.
                     inited <= (rsp.data == mmc_pkg::R1_READY);
                     state  <= ST_RELEASE;
                  end
               end
            end
            ST_R1:
            begin
               if (got && rsp.data != mmc_pkg::FILL_BYTE)
               begin
                  if (rsp.data == mmc_pkg::R1_READY)
                     state <= ST_TOKEN;
                  else
                  begin
                     bd_err <= 1'b1;
                     state  <= ST_RELEASE;
                  end
               end
            end
            ST_TOKEN:
            begin
               if (is_write && push)
                  state <= ST_HOST;
               else if (!is_write && got && rsp.data == mmc_pkg::START_TOKEN)
                  state <= ST_RD_WORD;
            end
            ST_RD_WORD:
            begin
               if (got)
               begin
                  if (byte_idx[0])
                  begin
                     rd_word[15:8] <= rsp.data;
                     byte_idx      <= '0;
                     state         <= ST_HOST;
                  end
                  else
                  begin
                     rd_word[7:0] <= rsp.data;
                     byte_idx     <= 4'd1;
                  end
               end
            end
            ST_HOST:
            begin
               if (bd_rd && !is_write)
               begin
                  wc    <= wc + 1'b1;
                  state <= (wc == WC_W'(WORDS_PER_BLOCK - 1)) ? ST_CRC : ST_RD_WORD;
               end
               else if (bd_wr && is_write)
               begin
                  wc      <= wc + 1'b1;
                  wr_word <= bd_data_in;
                  state   <= ST_WR_WORD;
               end
            end
            ST_WR_WORD:
            begin
               if (push)
               begin
                  byte_idx <= 4'd1;
                  if (byte_idx[0])
                  begin
                     byte_idx <= '0;
                     state    <= (wc == WC_W'(WORDS_PER_BLOCK)) ? ST_CRC : ST_HOST;
                  end
               end
            end
            ST_CRC:
            begin
               if (push)
               begin
                  byte_idx <= 4'd1;
                  if (byte_idx[0])
                  begin
                     byte_idx <= '0;
                     state    <= is_write ? ST_DATA_RSP : ST_RELEASE;
                  end
               end
            end
            ST_DATA_RSP:
            begin
               if (got && rsp.data != mmc_pkg::FILL_BYTE)
               begin
                  if (rsp.data[4:0] == mmc_pkg::DATA_ACCEPTED)
                     state <= ST_BUSY;
                  else
                  begin
                     bd_err <= 1'b1;
                     state  <= ST_RELEASE;
                  end
               end
            end
            ST_BUSY:
            begin
               // Card holds its output low while programming.
               if (got && rsp.data != 8'h00)
                  state <= ST_RELEASE;
            end
            ST_RELEASE:
            begin
               if (push)
               begin
                  if (cmd_code == mmc_pkg::CMD_GO_IDLE)
                  begin
                     cmd_code <= mmc_pkg::CMD_SEND_OP_COND;
                     state    <= ST_CMD;
                  end
                  else if (cmd_code == mmc_pkg::CMD_SEND_OP_COND && !inited)
                     state <= ST_CMD;
                  else if (cmd_code == mmc_pkg::CMD_SEND_OP_COND &&
                           cmd_hold != mmc_pkg::HOST_RESET)
                  begin
                     cmd_code <= rw_cmd(cmd_hold);
                     state    <= ST_CMD;
                  end
                  else
                     state <= ST_IDLE;
               end
            end
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   a_iordy_busy: assert property (@(posedge clk) disable iff (reset)
      bd_iordy |-> bd_bsy)
      else $error("Word handshake ready outside a command.");

   a_host_strobe: assert property (@(posedge clk) disable iff (reset)
      (bd_rd || bd_wr) |-> bd_iordy)
      else $error("Host word strobe without bd_iordy.");

endmodule

`default_nettype wire

//--- hdl/mmc_block_dev.sv
// Top of the MMC SPI block device, joining sequencer, operation queue and byte engine.
`timescale 1ns/1ps
`default_nettype none

module mmc_block_dev #(
   parameter int CLK_DIV         = 4,
   parameter int WORDS_PER_BLOCK = 256,
   parameter int QUEUE_DEPTH     = 8
) (
   input  logic                 clk,
   input  logic                 reset,
   input  mmc_pkg::host_cmd_e   bd_cmd,
   input  logic                 bd_start,
   input  mmc_pkg::block_addr_t bd_addr,
   input  mmc_pkg::word_t       bd_data_in,
   input  logic                 bd_rd,
   input  logic                 bd_wr,
   output logic                 bd_bsy,
   output logic                 bd_err,
   output logic                 bd_iordy,
   output mmc_pkg::word_t       bd_data_out,
   output logic                 mmc_cs,
   output logic                 mmc_sclk,
   output logic                 mmc_do,
   input  logic                 mmc_di
);

   mmc_pkg::spi_op_t  seq_op;
   logic              seq_op_valid;
   logic              seq_op_ready;
   mmc_pkg::spi_op_t  eng_op;
   logic              eng_op_valid;
   logic              eng_op_ready;
   mmc_pkg::spi_rsp_t eng_rsp;

   block_sequencer #(
      .WORDS_PER_BLOCK(WORDS_PER_BLOCK)
   ) u_seq (
      .clk         (clk),
      .reset       (reset),
      .bd_cmd      (bd_cmd),
      .bd_start    (bd_start),
      .bd_addr     (bd_addr),
      .bd_data_in  (bd_data_in),
      .bd_rd       (bd_rd),
      .bd_wr       (bd_wr),
      .bd_bsy      (bd_bsy),
      .bd_err      (bd_err),
      .bd_iordy    (bd_iordy),
      .bd_data_out (bd_data_out),
      .op          (seq_op),
      .op_valid    (seq_op_valid),
      .op_ready    (seq_op_ready),
      .rsp         (eng_rsp)
   );

   spi_op_queue #(
      .QUEUE_DEPTH(QUEUE_DEPTH)
   ) u_queue (
      .clk       (clk),
      .reset     (reset),
      .in_op     (seq_op),
      .in_valid  (seq_op_valid),
      .in_ready  (seq_op_ready),
      .out_op    (eng_op),
      .out_valid (eng_op_valid),
      .out_ready (eng_op_ready)
   );

   spi_byte_engine #(
      .CLK_DIV(CLK_DIV)
   ) u_engine (
      .clk      (clk),
      .reset    (reset),
      .op       (eng_op),
      .op_valid (eng_op_valid),
      .op_ready (eng_op_ready),
      .rsp      (eng_rsp),
      .mmc_cs   (mmc_cs),
      .mmc_sclk (mmc_sclk),
      .mmc_do   (mmc_do),
      .mmc_di   (mmc_di)
   );

endmodule

`default_nettype wire

//--- testbench/mmc_card_model.sv
// Behavioral SPI-mode MMC card with a sparse block memory, instantiated by the testbench.
`timescale 1ns/1ps
`default_nettype none

module mmc_card_model #(
   parameter int WORDS_PER_BLOCK = 256,
   parameter int BUSY_BYTES      = 3
) (
   input  logic mmc_cs,
   input  logic mmc_sclk,
   input  logic mmc_do,
   output logic mmc_di
);

   typedef enum int {
      M_CMD,
      M_WAIT_TOKEN,
      M_DATA
   } mode_e;

   mode_e       mode;
   logic [7:0]  rx;
   logic [7:0]  tx;
   int          bit_cnt;
   bit          byte_done;
   logic [7:0]  out_q[$];
   logic [7:0]  cmd_buf[6];
   int          cmd_len;
   int          data_cnt;
   int          op_cond_polls;
   int          wr_block;
   logic [7:0]  lo_byte;
   logic [15:0] mem[int];

   // Every command seen, with its argument.
   logic [7:0]  cmd_log[$];
   logic [31:0] addr_log[$];

   assign mmc_di = tx[7];

   // Unwritten words carry a pattern built from the whole word address.
   function automatic logic [15:0] word_at(input int blk, input int i);
      int key;
      key = blk * WORDS_PER_BLOCK + i;
      if (mem.exists(key))
         return mem[key];
      return 16'(key) ^ 16'(key >>> 16) ^ 16'h5a00;
   endfunction

   task automatic run_command();
      logic [7:0]  code;
      logic [31:0] addr;
      logic [15:0] w;
      int          blk;
      code = cmd_buf[0];
      addr = {cmd_buf[1], cmd_buf[2], cmd_buf[3], cmd_buf[4]};
      blk  = int'(addr >> 9);
      cmd_log.push_back(code);
      addr_log.push_back(addr);
      out_q.push_back(8'hff);
      if ((code == 8'h51 || code == 8'h58) && blk == 32'h7fffff)
         out_q.push_back(8'h04);
      else
      begin
         case (code)
            8'h40:
            begin
               op_cond_polls = 0;
               out_q.push_back(8'h01);
            end
            8'h41:
            begin
               op_cond_polls++;
               out_q.push_back((op_cond_polls <= 2) ? 8'h01 : 8'h00);
            end
            8'h51:
            begin
               out_q.push_back(8'h00);
               out_q.push_back(8'hff);
               out_q.push_back(8'hff);
               out_q.push_back(8'hfe);
               for (int i = 0; i < WORDS_PER_BLOCK; i++)
               begin
                  w = word_at(blk, i);
                  out_q.push_back(w[7:0]);
                  out_q.push_back(w[15:8]);
               end
               out_q.push_back(8'hff);
               out_q.push_back(8'hff);
            end
            8'h58:
            begin
               out_q.push_back(8'h00);
               wr_block = blk;
               mode     = M_WAIT_TOKEN;
            end
            default:
               out_q.push_back(8'h04);
         endcase
      end
   endtask

   task automatic take_byte(input logic [7:0] b);
      case (mode)
         M_CMD:
         begin
            // A command starts with bits 01.
            if (cmd_len != 0 || b[7:6] == 2'b01)
            begin
               cmd_buf[cmd_len] = b;
               cmd_len++;
               if (cmd_len == 6)
               begin
                  cmd_len = 0;
                  run_command();
               end
            end
         end
         M_WAIT_TOKEN:
         begin
            if (b == 8'hfe)
            begin
               mode     = M_DATA;
               data_cnt = 0;
            end
         end
         default:
         begin
            if (data_cnt < 2 * WORDS_PER_BLOCK)
            begin
               if (data_cnt % 2 == 0)
                  lo_byte = b;
               else
                  mem[wr_block * WORDS_PER_BLOCK + data_cnt / 2] = {b, lo_byte};
            end
            data_cnt++;
            if (data_cnt == 2 * WORDS_PER_BLOCK + 2)
            begin
               out_q.push_back(8'h05);
               for (int i = 0; i < BUSY_BYTES; i++)
                  out_q.push_back(8'h00);
               mode = M_CMD;
            end
         end
      endcase
   endtask

   initial
   begin
      mode          = M_CMD;
      tx            = 8'hff;
      rx            = 8'hff;
      bit_cnt       = 0;
      byte_done     = 1'b0;
      cmd_len       = 0;
      data_cnt      = 0;
      op_cond_polls = 0;
      wr_block      = 0;
      lo_byte       = 8'h00;
   end

   // Samples on the rising edge, shifts out on the falling edge.
   always @(posedge mmc_sclk or negedge mmc_sclk or posedge mmc_cs)
   begin
      if (mmc_cs)
      begin
         out_q.delete();
         bit_cnt   = 0;
         byte_done = 1'b0;
         cmd_len   = 0;
         mode      = M_CMD;
         tx        = 8'hff;
      end
      else if (mmc_sclk)
      begin
         rx = {rx[6:0], mmc_do};
         bit_cnt++;
         if (bit_cnt == 8)
         begin
            bit_cnt   = 0;
            byte_done = 1'b1;
            take_byte(rx);
         end
      end
      else if (byte_done)
      begin
         byte_done = 1'b0;
         tx = (out_q.size() != 0) ? out_q.pop_front() : 8'hff;
      end
      else
         tx = {tx[6:0], 1'b1};
   end

endmodule

`default_nettype wire

//--- testbench/tb_mmc_block_dev.sv
// Testbench top for the MMC block device, replaying host operations from the stim file.
`timescale 1ns/1ps
`default_nettype none

module tb_mmc_block_dev;

   localparam int CLK_DIV = 4;
   localparam int WORDS   = 8;

   logic                 clk;
   logic                 reset;
   mmc_pkg::host_cmd_e   bd_cmd;
   logic                 bd_start;
   mmc_pkg::block_addr_t bd_addr;
   mmc_pkg::word_t       bd_data_in;
   logic                 bd_rd;
   logic                 bd_wr;
   logic                 bd_bsy;
   logic                 bd_err;
   logic                 bd_iordy;
   mmc_pkg::word_t       bd_data_out;
   logic                 mmc_cs;
   logic                 mmc_sclk;
   logic                 mmc_do;
   logic                 mmc_di;

   logic [1:0]           cmd_q[$];
   logic [22:0]          blk_q[$];
   logic                 err_q[$];
   logic [15:0]          word_q[$];
   int                   num_lines;
   bit                   loaded;
   bit                   card_inited;

   mmc_block_dev #(
      .CLK_DIV         (CLK_DIV),
      .WORDS_PER_BLOCK (WORDS),
      .QUEUE_DEPTH     (8)
   ) u_dut (
      .clk         (clk),
      .reset       (reset),
      .bd_cmd      (bd_cmd),
      .bd_start    (bd_start),
      .bd_addr     (bd_addr),
      .bd_data_in  (bd_data_in),
      .bd_rd       (bd_rd),
      .bd_wr       (bd_wr),
      .bd_bsy      (bd_bsy),
      .bd_err      (bd_err),
      .bd_iordy    (bd_iordy),
      .bd_data_out (bd_data_out),
      .mmc_cs      (mmc_cs),
      .mmc_sclk    (mmc_sclk),
      .mmc_do      (mmc_do),
      .mmc_di      (mmc_di)
   );

   mmc_card_model #(
      .WORDS_PER_BLOCK (WORDS)
   ) u_card (
      .mmc_cs   (mmc_cs),
      .mmc_sclk (mmc_sclk),
      .mmc_do   (mmc_do),
      .mmc_di   (mmc_di)
   );

   task automatic report_mismatch(input string msg);
      $display("Mismatch at %0t ns: %s", $time, msg);
      $display("Testbench failed");
      $fatal(1, "Stopped on first error.");
   endtask

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Testbench failed");
      $fatal(1, "Run aborted.");
   endtask

   task automatic read_stim();
      int          fd;
      int          n;
      string       line;
      logic [1:0]  c;
      logic [22:0] b;
      logic        e;
      logic [15:0] w[8];
      fd = $fopen("testbench/mmc_stim.txt", "r");
      if (fd == 0)
         abort_run("Could not open testbench/mmc_stim.txt.");
      while ($fgets(line, fd) != 0)
      begin
         if (line.len() > 1 && line.getc(0) != "/")
         begin
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", c, b, e,
                        w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]);
            if (n != 11)
               abort_run({"Malformed stim line: ", line});
            cmd_q.push_back(c);
            blk_q.push_back(b);
            err_q.push_back(e);
            for (int i = 0; i < WORDS; i++)
               word_q.push_back(w[i]);
         end
      end
      $fclose(fd);
      num_lines = cmd_q.size();
   endtask

   task automatic run_line(input int idx);
      mmc_pkg::host_cmd_e c;
      int                 log_start;
      int                 moved;
      int                 gap;
      int                 last;
      int                 exp_words;
      c         = mmc_pkg::host_cmd_e'(cmd_q[idx]);
      log_start = u_card.cmd_log.size();
      @(posedge clk);
      bd_start <= 1'b1;
      bd_cmd   <= c;
      bd_addr  <= blk_q[idx];
      @(posedge clk);
      bd_start <= 1'b0;
      @(negedge clk);
      assert (bd_bsy === 1'b1 && bd_err === 1'b0)
         else report_mismatch($sformatf("line %0d: bd_bsy not high or bd_err set after start",
                              idx));
      moved = 0;
      while (bd_bsy)
      begin
         if (bd_iordy)
         begin
            assert (moved < WORDS)
               else report_mismatch($sformatf("line %0d: more than %0d words offered", idx,
                                    WORDS));
            if (c == mmc_pkg::HOST_READ)
               assert (bd_data_out === word_q[idx * WORDS + moved])
                  else report_mismatch($sformatf("line %0d word %0d: got %h, expected %h", idx,
                                       moved, bd_data_out, word_q[idx * WORDS + moved]));
            gap = int'($urandom % 6);
            repeat (gap) @(posedge clk);
            @(posedge clk);
            if (c == mmc_pkg::HOST_READ)
               bd_rd <= 1'b1;
            else
               bd_wr <= 1'b1;
            bd_data_in <= word_q[idx * WORDS + moved];
            @(posedge clk);
            bd_rd <= 1'b0;
            bd_wr <= 1'b0;
            moved++;
         end
         @(negedge clk);
      end
      assert (bd_err === err_q[idx])
         else report_mismatch($sformatf("line %0d: bd_err %b, expected %b", idx, bd_err,
                              err_q[idx]));
      exp_words = (c == mmc_pkg::HOST_RESET || err_q[idx]) ? 0 : WORDS;
      assert (moved == exp_words)
         else report_mismatch($sformatf("line %0d: %0d words moved, expected %0d", idx, moved,
                              exp_words));
      last = u_card.cmd_log.size() - 1;
      // Initialization must open with CMD0 and reach CMD1.
      if (c == mmc_pkg::HOST_RESET || !card_inited)
         assert (last > log_start && u_card.cmd_log[log_start] == 8'h40 &&
                 u_card.cmd_log[log_start + 1] == 8'h41)
            else report_mismatch($sformatf("line %0d: CMD0 then CMD1 not seen by the card", idx));
      if (c != mmc_pkg::HOST_RESET)
         assert (u_card.cmd_log[last] == ((c == mmc_pkg::HOST_READ) ? 8'h51 : 8'h58) &&
                 u_card.addr_log[last] == {blk_q[idx], 9'd0})
            else report_mismatch($sformatf("line %0d: card saw command %h address %h", idx,
                                 u_card.cmd_log[last], u_card.addr_log[last]));
      card_inited = 1'b1;
   endtask

   initial
   begin
      clk = 1'b0;
      forever #4 clk = !clk;
   end

   initial
   begin
      longint limit;
      wait (loaded);
      limit = longint'(num_lines) * 400 * 16 * CLK_DIV * 8;
      #(limit);
      abort_run("Timeout: the run took longer than the watchdog limit.");
   end

   initial
   begin
      void'($urandom(32'h5b15));
      reset       = 1'b1;
      bd_cmd      = mmc_pkg::HOST_RESET;
      bd_start    = 1'b0;
      bd_addr     = '0;
      bd_data_in  = '0;
      bd_rd       = 1'b0;
      bd_wr       = 1'b0;
      card_inited = 1'b0;
      loaded      = 1'b0;
      read_stim();
      loaded = 1'b1;
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      assert (bd_bsy === 1'b0 && bd_err === 1'b0 && bd_iordy === 1'b0 && mmc_cs === 1'b1 &&
              mmc_sclk === 1'b0)
         else report_mismatch("outputs after reset not idle");
      for (int i = 0; i < num_lines; i++)
         run_line(i);
      $display("Testbench passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- testbench/mmc_stim.txt
// cmd (0 reset, 1 read, 2 write), block, expected bd_err, then eight data words, all hex.
// Read lines hold expected words, write lines hold words to store.
1 000003 0 5a18 5a19 5a1a 5a1b 5a1c 5a1d 5a1e 5a1f
0 000000 0 0000 0000 0000 0000 0000 0000 0000 0000
2 000005 0 1111 2222 4c4f 8001 00ff ff00 a5a5 5a5a
1 000005 0 1111 2222 4c4f 8001 00ff ff00 a5a5 5a5a
2 000009 0 dead beef 0123 4567 89ab cdef fedc ba98
1 000003 0 5a18 5a19 5a1a 5a1b 5a1c 5a1d 5a1e 5a1f
1 000009 0 dead beef 0123 4567 89ab cdef fedc ba98
1 7fffff 1 0000 0000 0000 0000 0000 0000 0000 0000
2 7fffff 1 0000 0000 0000 0000 0000 0000 0000 0000
1 000005 0 1111 2222 4c4f 8001 00ff ff00 a5a5 5a5a

//--- vlog.f
hdl/mmc_pkg.sv
hdl/spi_op_queue.sv
hdl/spi_byte_engine.sv
hdl/block_sequencer.sv
hdl/mmc_block_dev.sv
testbench/mmc_card_model.sv
testbench/tb_mmc_block_dev.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; the exit status is the verdict.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_mmc_block_dev \
   -f vlog.f -o sim_tb \
   && ./obj_dir/sim_tb \
   || { echo "Simulation failed"; exit 1; }
